/* hw/tv_pkg.sv */
//////////////////////////////////////////////////
// Shared types and constants of the video path
// One CLK per pixel, 260x262 frame, 192x222 picture
//////////////////////////////////////////////////

package tv_pkg;

  typedef logic [12:0] addr_t;

  localparam addr_t BGM_BASE = 13'h1000; // 512 bytes up to 0x11FF
  localparam addr_t REG_BASE = 13'h1400; // Registers 0..3

  typedef struct packed {
    addr_t      addr;
    logic [7:0] data;
  } host_req_t;

  typedef struct packed {
    logic       bm_ena;
    logic       bm_lores; // Set selects low resolution
    logic [3:0] clr_bg;
    logic [3:0] clr_fg;   // High resolution only
  } video_cfg_t;

  typedef struct packed {
    logic [8:0] row;
    logic [8:0] col;
  } beam_t;

  //////////////////////////////////////////////////
  // Frame geometry

  localparam logic [8:0] FIRST_ROW_RENDER = 9'd24;
  localparam logic [8:0] RENDER_ROWS      = 9'd222;
  localparam logic [8:0] FIRST_COL_RENDER = 9'd24;
  localparam logic [8:0] RENDER_COLS      = 9'd192;
  localparam logic [8:0] PRE_RENDER_ROWS  = 9'd2; // Rows fetched ahead of the picture

  localparam int H_TOTAL_DEF = 260;
  localparam int V_TOTAL_DEF = 262;

  typedef logic [3:0] pixel_t;
  typedef pixel_t [7:0] lb_word_t; // Leftmost pixel in bits 3:0

  typedef struct packed {
    logic       sel;  // Target row of the ping-pong pair
    logic [4:0] addr; // Tile
    lb_word_t   data;
    logic [7:0] we;   // One per pixel
  } lb_write_t;

  // {R,G,B}
  localparam logic [23:0] PALETTE [16] = '{
    24'h00009b, 24'h000000, 24'h0000ff, 24'ha100ff,
    24'h00ff00, 24'ha0ff9d, 24'h00ffff, 24'h00a100,
    24'hff0000, 24'hffa100, 24'hff00ff, 24'hffa09f,
    24'hffff00, 24'ha3a000, 24'ha1a09d, 24'hffffff
  };

  localparam pixel_t BORDER_COLOR = 4'd1; // Black

endpackage

/* hw/host_regs.sv */
//////////////////////////////////////////////////
// Host write port, control registers and BGM
// Write only, one write per four-phase handshake
//////////////////////////////////////////////////

module host_regs (
  input  logic               CLK,
  input  logic               reset,
  input  logic               req,
  input  tv_pkg::host_req_t  req_data,
  output logic               ack,
  output tv_pkg::video_cfg_t cfg,
  input  logic [6:0]         bgm_raddr,
  output logic [31:0]        bgm_rdata
);

  logic        wr_stb;
  logic        sel_bgm;
  logic        sel_reg;
  logic [3:0]  bgm_be;
  logic [7:0]  regs [4];
  logic [31:0] bgm [128];

  // One strobe per request, in the cycle ack rises
  assign wr_stb = req & ~ack;

  // Anything outside both windows is acked and dropped
  assign sel_bgm = (req_data.addr[12:9] == tv_pkg::BGM_BASE[12:9]);
  assign sel_reg = (req_data.addr[12:2] == tv_pkg::REG_BASE[12:2]);

  //////////////////////////////////////////////////
  // Four-phase handshake

  always_ff @(posedge CLK) begin
    if (reset) begin
      ack <= 1'b0;
    end else if (req & ~ack) begin
      ack <= 1'b1;
    end else if (~req & ack) begin
      ack <= 1'b0;
    end
  end

  // Registers 2 and 3 are kept but drive nothing
  always_ff @(posedge CLK) begin
    if (reset) begin
      for (int i = 0; i < 4; i++) begin
        regs[i] <= 8'h00;
      end
    end else if (wr_stb & sel_reg) begin
      regs[req_data.addr[1:0]] <= req_data.data;
    end
  end

  assign cfg.bm_ena   = regs[0][0];
  assign cfg.bm_lores = regs[0][1];
  assign cfg.clr_bg   = regs[1][3:0];
  assign cfg.clr_fg   = regs[1][7:4];

  //////////////////////////////////////////////////
  // Background memory, 128 words of 4 bytes

  assign bgm_be = {3'b000, wr_stb & sel_bgm} << req_data.addr[1:0];

  always_ff @(posedge CLK) begin
    for (int i = 0; i < 4; i++) begin
      if (bgm_be[i]) begin
        bgm[req_data.addr[8:2]][i*8 +: 8] <= req_data.data;
      end
    end
    bgm_rdata <= bgm[bgm_raddr]; // Old data on a same-word collision
  end

endmodule

/* hw/video_timing.sv */
//////////////////////////////////////////////////
// Free-running beam counter and sync generation
// Sync outputs lag the beam by two cycles
//////////////////////////////////////////////////

module video_timing #(
  parameter int H_TOTAL = tv_pkg::H_TOTAL_DEF,
  parameter int V_TOTAL = tv_pkg::V_TOTAL_DEF
) (
  input  logic          CLK,
  input  logic          reset,
  output tv_pkg::beam_t beam,
  output logic          fetch_line,
  output logic          lb_rd_sel,
  output logic          de,
  output logic          hs,
  output logic          vs,
  output logic          vbl
);

  localparam logic [8:0] COL_LAST = 9'(H_TOTAL - 1);
  localparam logic [8:0] ROW_LAST = 9'(V_TOTAL - 1);
  localparam logic [8:0] HS_START = 9'(H_TOTAL - 4);
  localparam logic [8:0] VS_START = 9'(V_TOTAL - 6);

  typedef struct packed {
    logic de;
    logic hs;
    logic vs;
    logic vbl;
  } sync_t;

  logic [8:0] row;
  logic [8:0] col;
  logic       render_row;
  logic       pre_render_row;
  logic       render_col;
  sync_t      sync_now;
  sync_t      sync_d1;
  sync_t      sync_d2;

  always_ff @(posedge CLK) begin
    if (reset) begin
      row <= 9'd0;
      col <= 9'd0;
    end else if (col == COL_LAST) begin
      col <= 9'd0;
      row <= (row == ROW_LAST) ? 9'd0 : row + 9'd1;
    end else begin
      col <= col + 9'd1;
    end
  end

  assign render_row = (row >= tv_pkg::FIRST_ROW_RENDER) &
                      (row < tv_pkg::FIRST_ROW_RENDER + tv_pkg::RENDER_ROWS);
  assign pre_render_row = (row >= tv_pkg::FIRST_ROW_RENDER - tv_pkg::PRE_RENDER_ROWS) &
                          (row < tv_pkg::FIRST_ROW_RENDER);
  assign render_col = (col >= tv_pkg::FIRST_COL_RENDER) &
                      (col < tv_pkg::FIRST_COL_RENDER + tv_pkg::RENDER_COLS);

  assign beam.row   = row;
  assign beam.col   = col;
  assign fetch_line = (col == 9'd0) & (pre_render_row | render_row); // Next line's data
  assign lb_rd_sel  = row[0];

  assign sync_now.de  = render_row & render_col;
  assign sync_now.hs  = (col >= HS_START) | (col <= 9'd15);
  assign sync_now.vs  = (row >= VS_START) | (row <= 9'd2);
  assign sync_now.vbl = ~render_row;

  // Two stages to match buffer read and palette
  always_ff @(posedge CLK) begin
    if (reset) begin
      sync_d1 <= '0;
      sync_d2 <= '0;
    end else begin
      sync_d1 <= sync_now;
      sync_d2 <= sync_d1;
    end
  end

  assign de  = sync_d2.de;
  assign hs  = sync_d2.hs;
  assign vs  = sync_d2.vs;
  assign vbl = sync_d2.vbl;

endmodule

/* hw/bg_line_fetch.sv */
//////////////////////////////////////////////////
// Bitmap fetch for the next line, one tile per CLK
// Tile t lands in the line buffer at col t+2
//////////////////////////////////////////////////

module bg_line_fetch (
  input  logic               CLK,
  input  logic               reset,
  input  tv_pkg::beam_t      beam,
  input  logic               fetch_line,
  input  tv_pkg::video_cfg_t cfg,
  output logic [6:0]         bgm_raddr,
  input  logic [31:0]        bgm_rdata,
  output tv_pkg::lb_write_t  lb_wr
);

  logic             active;
  logic [5:0]       idx;      // 32 ends the walk
  logic [4:0]       tile;
  logic             issue;
  logic             rd_valid;
  logic [4:0]       rd_tile;
  logic [1:0]       rd_ysel;  // Row bits 3:2
  logic             rd_sel;
  logic [7:0]       bm_byte;
  logic [3:0]       lo_nib;
  logic [1:0]       hi_pair;
  logic [7:0]       pat;
  tv_pkg::pixel_t   clr_off;
  tv_pkg::pixel_t   clr_on;
  tv_pkg::lb_word_t word;

  // Tile 0 goes out in the fetch_line cycle itself
  assign tile      = fetch_line ? 5'd0 : idx[4:0];
  assign issue     = fetch_line | (active & ~idx[5]);
  assign bgm_raddr = {beam.row[7:4], tile[4:2]};

  always_ff @(posedge CLK) begin
    if (reset) begin
      active <= 1'b0;
      idx    <= 6'd0;
    end else if (fetch_line) begin
      active <= 1'b1;
      idx    <= 6'd1;
    end else if (active) begin
      if (idx[5]) begin
        active <= 1'b0;
      end else begin
        idx <= idx + 6'd1;
      end
    end
  end

  // BGM read stage
  always_ff @(posedge CLK) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= issue;
    end
    rd_tile <= tile;
    rd_ysel <= beam.row[3:2];
    rd_sel  <= ~beam.row[0];
  end

  //////////////////////////////////////////////////
  // Bitmap decode

  always_comb begin
    bm_byte = bgm_rdata[rd_tile[1:0]*8 +: 8];
    lo_nib  = rd_ysel[1] ? bm_byte[3:0] : bm_byte[7:4]; // Upper half-cell in the high nibble
    hi_pair = bm_byte[{~rd_ysel, 1'b0} +: 2];
    clr_off = cfg.clr_bg;
    clr_on  = cfg.clr_fg;
    pat     = 8'h00;
    if (cfg.bm_ena) begin
      if (cfg.bm_lores) begin
        clr_off = lo_nib;
      end else begin
        pat = {{4{hi_pair[1]}}, {4{hi_pair[0]}}};
      end
    end
    // MSB of the pattern is the leftmost pixel
    for (int i = 0; i < 8; i++) begin
      word[i] = pat[7-i] ? clr_on : clr_off;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      lb_wr.we <= 8'h00;
    end else begin
      lb_wr.we <= {8{rd_valid}};
    end
    lb_wr.sel  <= rd_sel;
    lb_wr.addr <= rd_tile;
    lb_wr.data <= word;
  end

endmodule

/* hw/line_buffer_row.sv */
//////////////////////////////////////////////////
// One line buffer row, 32 words of 8 pixels
// Reads are undefined while the row is selected for write
//////////////////////////////////////////////////

module line_buffer_row #(
  parameter bit ROW_ID = 1'b0
) (
  input  logic              CLK,
  input  tv_pkg::lb_write_t lb_wr,
  input  logic [4:0]        rd_addr,
  output tv_pkg::lb_word_t  rd_data
);

  tv_pkg::lb_word_t mem [32];

  logic       wr_row;
  logic [4:0] addr;
  logic [7:0] we;

  // Single address port, the fetcher owns it when selected
  assign wr_row = (lb_wr.sel == ROW_ID);
  assign addr   = wr_row ? lb_wr.addr : rd_addr;
  assign we     = wr_row ? lb_wr.we : 8'h00;

  always_ff @(posedge CLK) begin
    rd_data <= mem[addr];
    for (int i = 0; i < 8; i++) begin
      if (we[i]) begin
        mem[addr][i] <= lb_wr.data[i];
      end
    end
  end

endmodule

/* hw/pixel_scanout.sv */
//////////////////////////////////////////////////
// Line buffer readout, border and palette
// RGB lags the beam by two cycles
//////////////////////////////////////////////////

module pixel_scanout (
  input  logic                   CLK,
  input  logic                   reset,
  input  tv_pkg::beam_t          beam,
  input  logic                   lb_rd_sel,
  input  tv_pkg::lb_word_t [1:0] row_data,
  output logic [4:0]             rd_addr,
  output logic [23:0]            rgb
);

  logic           render_px;
  logic           render_d;
  logic           sel_d;
  logic [2:0]     off_d;
  tv_pkg::pixel_t pix;

  assign render_px = (beam.row >= tv_pkg::FIRST_ROW_RENDER) &
                     (beam.row < tv_pkg::FIRST_ROW_RENDER + tv_pkg::RENDER_ROWS) &
                     (beam.col >= tv_pkg::FIRST_COL_RENDER) &
                     (beam.col < tv_pkg::FIRST_COL_RENDER + tv_pkg::RENDER_COLS);

  assign rd_addr = beam.col[7:3]; // Tile under the beam

  // Align with the registered buffer read
  always_ff @(posedge CLK) begin
    if (reset) begin
      render_d <= 1'b0;
    end else begin
      render_d <= render_px;
    end
    sel_d <= lb_rd_sel;
    off_d <= beam.col[2:0];
  end

  assign pix = render_d ? row_data[sel_d][off_d] : tv_pkg::BORDER_COLOR;

  always_ff @(posedge CLK) begin
    if (reset) begin
      rgb <= 24'h000000;
    end else begin
      rgb <= tv_pkg::PALETTE[pix];
    end
  end

endmodule

/* hw/tv_top.sv */
//////////////////////////////////////////////////
// Background video path, one pixel per CLK
// All outputs describe the beam two cycles back
//////////////////////////////////////////////////

module tv_top #(
  parameter int H_TOTAL = tv_pkg::H_TOTAL_DEF,
  parameter int V_TOTAL = tv_pkg::V_TOTAL_DEF
) (
  input  logic              CLK,
  input  logic              reset,
  input  logic              req,
  input  tv_pkg::host_req_t req_data,
  output logic              ack,
  output logic [23:0]       rgb,
  output logic              de,
  output logic              hs,
  output logic              vs,
  output logic              vbl
);

  tv_pkg::video_cfg_t     cfg;
  tv_pkg::beam_t          beam;
  tv_pkg::lb_write_t      lb_wr;
  tv_pkg::lb_word_t [1:0] row_data;
  logic                   fetch_line;
  logic                   lb_rd_sel;
  logic [6:0]             bgm_raddr;
  logic [31:0]            bgm_rdata;
  logic [4:0]             rd_addr;

  host_regs i_host_regs (
    .CLK       (CLK),
    .reset     (reset),
    .req       (req),
    .req_data  (req_data),
    .ack       (ack),
    .cfg       (cfg),
    .bgm_raddr (bgm_raddr),
    .bgm_rdata (bgm_rdata)
  );

  video_timing #(
    .H_TOTAL (H_TOTAL),
    .V_TOTAL (V_TOTAL)
  ) i_video_timing (
    .CLK        (CLK),
    .reset      (reset),
    .beam       (beam),
    .fetch_line (fetch_line),
    .lb_rd_sel  (lb_rd_sel),
    .de         (de),
    .hs         (hs),
    .vs         (vs),
    .vbl        (vbl)
  );

  bg_line_fetch i_bg_line_fetch (
    .CLK        (CLK),
    .reset      (reset),
    .beam       (beam),
    .fetch_line (fetch_line),
    .cfg        (cfg),
    .bgm_raddr  (bgm_raddr),
    .bgm_rdata  (bgm_rdata),
    .lb_wr      (lb_wr)
  );

  // Ping-pong pair, one filled while the other is shown
  for (genvar i = 0; i < 2; i++) begin : g_lb_row
    line_buffer_row #(
      .ROW_ID (1'(i))
    ) i_line_buffer_row (
      .CLK     (CLK),
      .lb_wr   (lb_wr),
      .rd_addr (rd_addr),
      .rd_data (row_data[i])
    );
  end

  pixel_scanout i_pixel_scanout (
    .CLK       (CLK),
    .reset     (reset),
    .beam      (beam),
    .lb_rd_sel (lb_rd_sel),
    .row_data  (row_data),
    .rd_addr   (rd_addr),
    .rgb       (rgb)
  );

endmodule

/* testbench/tv_chk.sv */
//////////////////////////////////////////////////
// Host handshake and sync checks, bound into tv_top
//////////////////////////////////////////////////

module tv_chk (
  input logic CLK,
  input logic reset,
  input logic req,
  input logic ack,
  input logic de,
  input logic hs,
  input logic vs,
  input logic vbl
);

  // Ack only answers a pending request
  a_ack_rise: assert property (@(posedge CLK) disable iff (reset)
    $rose(ack) |-> $past(req))
    else $error("ack rose without a request");

  a_ack_hold: assert property (@(posedge CLK) disable iff (reset)
    (ack && req) |=> ack)
    else $error("ack dropped while req was still high");

  a_ack_fall: assert property (@(posedge CLK) disable iff (reset)
    (ack && !req) |=> !ack)
    else $error("ack stayed high after req fell");

  // Sync pulses sit inside the blanking intervals
  a_de_hs: assert property (@(posedge CLK) disable iff (reset)
    de |-> !hs)
    else $error("DE high during horizontal sync");

  a_vs_vbl: assert property (@(posedge CLK) disable iff (reset)
    vs |-> vbl)
    else $error("VS high outside vertical blank");

endmodule

bind tv_top tv_chk i_tv_chk (
  .CLK   (CLK),
  .reset (reset),
  .req   (req),
  .ack   (ack),
  .de    (de),
  .hs    (hs),
  .vs    (vs),
  .vbl   (vbl)
);

/* testbench/tv_tb.sv */
//////////////////////////////////////////////////
// Random BGM and register writes, frame checked against a pixel model
// Runs three passes: low res, high res, bitmap off
//////////////////////////////////////////////////

module tv_tb;

  localparam int H_TOTAL     = tv_pkg::H_TOTAL_DEF;
  localparam int V_TOTAL     = tv_pkg::V_TOTAL_DEF;
  localparam int CYCLE_LIMIT = 6 * H_TOTAL * V_TOTAL + 3 * 2000;

  logic              CLK;
  logic              reset;
  logic              req;
  tv_pkg::host_req_t req_data;
  logic              ack;
  logic [23:0]       rgb;
  logic              de;
  logic              hs;
  logic              vs;
  logic              vbl;

  logic [15:0] lfsr;
  logic [7:0]  bgm_model [512];
  logic [7:0]  regs_model [4];
  logic [7:0]  rnd;
  int          cycles;
  int          hs_len;
  int          hs_pulses;
  int          vs_len;
  int          vs_pulses;
  int          vbl_low;
  int          de_len;
  int          de_lines;
  int          frames_checked;
  int          target;
  logic        vs_prev;
  logic        check_req;
  logic        checking;

  tv_top #(
    .H_TOTAL (H_TOTAL),
    .V_TOTAL (V_TOTAL)
  ) i_tv_top (
    .CLK      (CLK),
    .reset    (reset),
    .req      (req),
    .req_data (req_data),
    .ack      (ack),
    .rgb      (rgb),
    .de       (de),
    .hs       (hs),
    .vs       (vs),
    .vbl      (vbl)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s, got 0x%0h, expected 0x%0h", $time, msg, actual, expected);
      stop_on_error();
    end
  endtask

  // Galois LFSR, taps 16,14,13,11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [7:0] v);
    v = 8'h00;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[6:0], lfsr[0]};
    end
  endtask

  ////////////////////////////////////////////////////
  // Pixel model, bitmap row taken from the line above

  function automatic logic [3:0] expected_index(input int r, input int c);
    logic [8:0] y;
    logic [8:0] x;
    logic [7:0] b;
    logic [1:0] pair;
    logic       bit_on;
    y      = 9'(r - 1);
    x      = 9'(c);
    b      = bgm_model[{y[7:4], x[7:3]}];
    pair   = b[{~y[3:2], 1'b0} +: 2];
    bit_on = x[2] ? pair[0] : pair[1];
    if (!regs_model[0][0]) begin
      expected_index = regs_model[1][3:0];
    end else if (regs_model[0][1]) begin
      expected_index = y[3] ? b[3:0] : b[7:4]; // Lower half-cell in the low nibble
    end else begin
      expected_index = bit_on ? regs_model[1][7:4] : regs_model[1][3:0];
    end
  endfunction

  // Four-phase write, entered and left 1 unit after a rising edge
  task automatic write_host(input tv_pkg::addr_t a, input logic [7:0] d);
    int waited;
    waited        = 0;
    req_data.addr = a;
    req_data.data = d;
    req           = 1'b1;
    while (ack !== 1'b1) begin
      @(posedge CLK);
      #1;
      waited++;
      if (waited > 16) begin
        $display("No ack for the write to address 0x%0h", a);
        stop_on_error();
      end
    end
    // Req held one cycle past ack
    @(posedge CLK);
    #1;
    req    = 1'b0;
    waited = 0;
    while (ack !== 1'b0) begin
      @(posedge CLK);
      #1;
      waited++;
      if (waited > 16) begin
        $display("Ack never fell after the write to address 0x%0h", a);
        stop_on_error();
      end
    end
    if (a >= tv_pkg::BGM_BASE && a <= tv_pkg::BGM_BASE + 13'h1FF) begin
      bgm_model[9'(a - tv_pkg::BGM_BASE)] = d;
    end else if (a >= tv_pkg::REG_BASE && a <= tv_pkg::REG_BASE + 13'd3) begin
      regs_model[a[1:0]] = d;
    end
  endtask

  // Checks the whole frame that starts at the next VS
  task automatic run_frame_check();
    target    = frames_checked + 1;
    check_req = 1'b1;
    wait (frames_checked == target);
    @(posedge CLK);
    #1;
  endtask

  always @(posedge CLK) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout, the run passed %0d cycles", CYCLE_LIMIT);
      stop_on_error();
    end
  end

  ////////////////////////////////////////////////////
  // Output monitor, sampled on the falling edge

  always @(negedge CLK) begin
    if (!reset) begin
      if (hs) begin
        hs_len++;
      end else if (hs_len != 0) begin
        if (hs_pulses > 0) check_value(hs_len, 20, "HS cycles per line");
        hs_pulses++;
        hs_len = 0;
      end
      if (vs) begin
        vs_len++;
      end else if (vs_len != 0) begin
        if (vs_pulses > 0) check_value(vs_len, 9 * H_TOTAL, "VS length in cycles");
        vs_pulses++;
        vs_len = 0;
      end
      if (!vbl) begin
        vbl_low++;
      end
      if (vs && !vs_prev) begin // Frame boundary
        if (vs_pulses > 0) begin
          check_value(de_lines, 222, "DE lines per frame");
          check_value(vbl_low, 222 * H_TOTAL, "VBL low cycles per frame");
        end
        de_lines = 0;
        vbl_low  = 0;
        if (checking) begin
          checking = 1'b0;
          frames_checked++;
        end else if (check_req) begin
          checking  = 1'b1;
          check_req = 1'b0;
        end
      end
      if (de) begin
        check_value({31'h0, vbl}, 32'h0, "VBL during DE");
        if (checking) begin
          check_value({8'h00, rgb},
                      {8'h00, tv_pkg::PALETTE[expected_index(24 + de_lines, 24 + de_len)]},
                      "RGB of a picture pixel");
        end
        de_len++;
      end else begin
        if (de_len != 0) begin
          check_value(de_len, 192, "DE pixels per line");
          de_lines++;
        end
        de_len = 0;
        if (!vbl) check_value({8'h00, rgb}, 32'h0, "RGB beside DE in a render row");
      end
      vs_prev = vs;
    end
  end

  initial begin
    lfsr           = 16'd30;
    reset          = 1'b1;
    req            = 1'b0;
    req_data       = '0;
    cycles         = 0;
    hs_len         = 0;
    hs_pulses      = 0;
    vs_len         = 0;
    vs_pulses      = 0;
    vbl_low        = 0;
    de_len         = 0;
    de_lines       = 0;
    frames_checked = 0;
    vs_prev        = 1'b0;
    check_req      = 1'b0;
    checking       = 1'b0;
    for (int i = 0; i < 4; i++) regs_model[i] = 8'h00;
    repeat (4) @(posedge CLK);
    #1;
    reset = 1'b0;
    @(posedge CLK);
    #1;
    check_value({31'h0, ack}, 32'h0, "ack after reset");
    check_value({31'h0, de}, 32'h0, "de after reset");

    // Low resolution with a random BGM
    for (int i = 0; i < 512; i++) begin
      take_bits(8, rnd);
      write_host(tv_pkg::BGM_BASE + 13'(i), rnd);
    end
    take_bits(8, rnd);
    write_host(tv_pkg::REG_BASE + 13'd1, rnd);
    write_host(tv_pkg::REG_BASE, 8'h03);
    // Unmapped, acked and dropped; aliases a shown byte and register 0
    write_host(13'h00A5, ~bgm_model[9'h0A5]);
    write_host(13'h12A5, ~bgm_model[9'h0A5]);
    write_host(13'h1404, 8'h00);
    write_host(13'h1403, rnd); // Register 3 has no effect
    run_frame_check();

    // High resolution, random colors
    take_bits(8, rnd);
    write_host(tv_pkg::REG_BASE + 13'd1, rnd);
    take_bits(8, rnd);
    write_host(tv_pkg::REG_BASE, (rnd & 8'hFC) | 8'h01);
    run_frame_check();

    // Bitmap off
    take_bits(8, rnd);
    write_host(tv_pkg::REG_BASE + 13'd1, rnd);
    take_bits(8, rnd);
    write_host(tv_pkg::REG_BASE, rnd & 8'hFE);
    run_frame_check();

    $display("TEST PASSED");
    $finish;
  end

endmodule

/* vlog.f */
hw/tv_pkg.sv
hw/host_regs.sv
hw/video_timing.sv
hw/bg_line_fetch.sv
hw/line_buffer_row.sv
hw/pixel_scanout.sv
hw/tv_top.sv
testbench/tv_chk.sv
testbench/tv_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds tv_tb with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module tv_tb -f vlog.f -o tv_sim > build.log 2>&1 \
  && ./obj_dir/tv_sim > sim.log 2>&1 \
  || echo "Build or run stopped with an error, see build.log and sim.log"
grep -q "^TEST PASSED$" sim.log 2>/dev/null && echo "Simulation passed" && exit 0
echo "Simulation failed"
exit 1
